// File: build.f
+incdir+common
common/audio_pkg.sv
common/dac_pkg.sv
source/spi_note_receiver.sv
voice/envelope_generator.sv
voice/note_mixer.sv
dac/dac_serializer.sv
source/piano_top.sv
tests/piano_tb.sv

// File: common/audio_pkg.sv
// audio sample, frame and voice types plus the envelope gain table, imported by the voice path
`include "piano_config.svh"

package audio_pkg;

    typedef logic [`SAMPLE_W-1:0] sample_t;
    typedef logic [1:0]           voice_count_t;   // 0 means silent
    typedef logic [7:0]           gain_mask_t;     // bit 7 whole, bit 0 one 128th

    typedef struct packed {
        sample_t      note1;
        sample_t      note2;
        sample_t      note3;
        voice_count_t count;
    } note_frame_t;

    typedef struct packed {
        sample_t sample;
        logic    active;
        logic    done;
    } voice_status_t;

    // swell over three stages, hold full level once, then fade out
    localparam gain_mask_t env_gain_table [`ENV_STAGES] = '{
        8'h20,   // 1/4
        8'h48,
        8'h70,
        8'h80,   // full level
        8'h7C,
        8'h70,
        8'h64,
        8'h58,
        8'h4C,
        8'h40,   // 1/2
        8'h34,
        8'h28,
        8'h1E,
        8'h14,
        8'h0A,
        8'h04
    };

endpackage

// File: common/dac_pkg.sv
// DAC frame phases and pin bundle, imported by the serializer and the top level
package dac_pkg;

    typedef enum logic [2:0] {
        PRE,    // dclk running, data idle
        DATA,   // eight bits, MSB first
        LOAD,   // load strobe low
        LDAC,   // ldac strobe low
        END     // latch next sample
    } dac_phase_t;

    typedef struct packed {
        logic dclk;
        logic data;
        logic load;
        logic ldac;
    } dac_pins_t;

endpackage

// File: common/piano_config.svh
// widths, sync word and timing constants, included by the packages and RTL that need them
`ifndef PIANO_CONFIG_SVH
`define PIANO_CONFIG_SVH

// audio and SPI framing
`define SAMPLE_W            8
`define FRAME_W             32
`define SYNC_WORD           32'h0000_FFFF

// DAC frame timing in clk cycles
`define DAC_BIT_CYCLES      8
`define DAC_PRE_BITS        4
`define DAC_LOAD_CYCLES     4
`define DAC_LDAC_CYCLES     4

// one complete DAC frame: idle bits, data bits, both strobes and the restart cycle
`define DAC_FRAME_CYCLES    ((`DAC_PRE_BITS + `SAMPLE_W) * `DAC_BIT_CYCLES + \
                             `DAC_LOAD_CYCLES + `DAC_LDAC_CYCLES + 1)

// envelope shape
`define ENV_STAGES          16
`define ENV_STAGE_CYCLES    (4 * `DAC_FRAME_CYCLES)

`endif

// File: dac/dac_serializer.sv
// serial DAC driver that shifts out one sample per frame and then strobes load and ldac
`timescale 1ns/1ps
`include "piano_config.svh"

module dac_serializer
    import audio_pkg::*;
    import dac_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  sample_t   mixed,
    output dac_pins_t pins
);

    localparam int HALF_BIT = `DAC_BIT_CYCLES / 2;

    dac_phase_t phase;
    logic [7:0] cycle_cnt;
    logic [7:0] cycle_limit;
    logic [3:0] bit_cnt;
    logic       last_cycle;
    logic       dclk_high;
    logic       bit_slot;
    sample_t    word;

    always_comb
    begin
        case (phase)
            PRE, DATA: cycle_limit = 8'(`DAC_BIT_CYCLES);
            LOAD:      cycle_limit = 8'(`DAC_LOAD_CYCLES);
            LDAC:      cycle_limit = 8'(`DAC_LDAC_CYCLES);
            default:   cycle_limit = 8'd1;
        endcase
    end

    assign last_cycle = (cycle_cnt == cycle_limit - 8'd1);
    assign dclk_high  = (cycle_cnt < 8'(HALF_BIT));   // first half of the bit period
    assign bit_slot   = (phase == DATA) && (cycle_cnt == 8'd1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase     <= END;   // first cycle latches a sample
            cycle_cnt <= '0;
            bit_cnt   <= '0;
        end
        else if (!last_cycle)
            cycle_cnt <= cycle_cnt + 8'd1;
        else
        begin
            cycle_cnt <= '0;
            case (phase)
                PRE:
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'(`DAC_PRE_BITS - 1))
                    begin
                        phase   <= DATA;
                        bit_cnt <= '0;
                    end
                end
                DATA:
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'(`SAMPLE_W - 1))
                    begin
                        phase   <= LOAD;
                        bit_cnt <= '0;
                    end
                end
                LOAD:
                    phase <= LDAC;
                LDAC:
                    phase <= END;
                default:
                    phase <= PRE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            word <= '0;
        else if (phase == END)
            word <= mixed;
        else if (bit_slot)
            word <= word << 1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pins <= '{dclk: 1'b0, data: 1'b0, load: 1'b1, ldac: 1'b1};
        else
        begin
            pins.dclk <= (phase == PRE || phase == DATA) && dclk_high;
            pins.load <= (phase != LOAD);
            pins.ldac <= (phase != LDAC);
            if (bit_slot)
                pins.data <= word[`SAMPLE_W-1];   // changes while dclk is high
            else if (phase != DATA)
                pins.data <= 1'b0;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# builds the tone mixer testbench with Verilator, runs it and scans the log for failures
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module piano_tb -f build.f

# the log is judged below, so a nonzero exit of the simulator must not stop the script here
./obj_dir/Vpiano_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: source/piano_top.sv
// three-voice tone mixer top level: SPI note frames in, serial DAC pins out
`timescale 1ns/1ps

module piano_top
    import audio_pkg::*;
    import dac_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      sck,
    input  logic      sdi,
    output dac_pins_t dac
);

    note_frame_t   frame;
    voice_status_t voices [3];
    sample_t       mixed;

    spi_note_receiver i_spi_note_receiver (
        .clk   (clk),
        .reset (reset),
        .sck   (sck),
        .sdi   (sdi),
        .frame (frame)
    );

    envelope_generator i_envelope_1 (
        .clk   (clk),
        .reset (reset),
        .note  (frame.note1),
        .voice (voices[0])
    );

    envelope_generator i_envelope_2 (
        .clk   (clk),
        .reset (reset),
        .note  (frame.note2),
        .voice (voices[1])
    );

    envelope_generator i_envelope_3 (
        .clk   (clk),
        .reset (reset),
        .note  (frame.note3),
        .voice (voices[2])
    );

    note_mixer i_note_mixer (
        .clk    (clk),
        .reset  (reset),
        .voices (voices),
        .count  (frame.count),
        .mixed  (mixed)
    );

    dac_serializer i_dac_serializer (
        .clk   (clk),
        .reset (reset),
        .mixed (mixed),
        .pins  (dac)
    );

endmodule

// File: source/spi_note_receiver.sv
// receive-only SPI link sampled on clk that unlocks on the sync word and then decodes note frames
`timescale 1ns/1ps
`include "piano_config.svh"

module spi_note_receiver
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        sck,
    input  logic        sdi,
    output note_frame_t frame
);

    logic [1:0]                  sck_sync;
    logic [1:0]                  sdi_sync;
    logic                        sck_last;
    logic                        sck_rise;
    logic [`FRAME_W-1:0]         shift;
    logic                        synced;
    logic [$clog2(`FRAME_W)-1:0] bit_cnt;
    logic                        frame_done;

    assign sck_rise = sck_sync[1] & ~sck_last;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sck_sync <= '0;
            sdi_sync <= '0;
            sck_last <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[0], sck};
            sdi_sync <= {sdi_sync[0], sdi};
            sck_last <= sck_sync[1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            shift      <= '0;
            synced     <= 1'b0;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (sck_rise)
            begin
                shift <= {shift[`FRAME_W-2:0], sdi_sync[1]};
                if (synced)
                begin
                    bit_cnt    <= bit_cnt + 1'b1;
                    frame_done <= (bit_cnt == '1);   // 32nd bit of the frame
                end
            end
            if (!synced && shift == `SYNC_WORD)
                synced <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            frame <= '0;
        else if (frame_done)
        begin
            frame.note1 <= shift[`SAMPLE_W-1:0];
            frame.note2 <= shift[2*`SAMPLE_W-1:`SAMPLE_W];
            frame.note3 <= shift[3*`SAMPLE_W-1:2*`SAMPLE_W];
            frame.count <= shift[3*`SAMPLE_W+1:3*`SAMPLE_W];
        end
    end

endmodule

// File: tests/piano_tb.sv
// testbench for the tone mixer that sends SPI note frames from a table and checks the DAC words
`timescale 1ns/1ps
`include "piano_config.svh"

module piano_tb
    import audio_pkg::*;
    import dac_pkg::*;
();

    localparam int SCK_HALF      = 6;   // clk cycles per sck half period
    localparam int FRAME_TIMEOUT = 2 * `DAC_FRAME_CYCLES;
    localparam int NUM_ROWS      = 13;

    localparam logic [2:0] IDLE_WORDS  = 3'd0;   // every word zero
    localparam logic [2:0] ANY_NONZERO = 3'd1;
    localparam logic [2:0] ENV_SHAPE   = 3'd2;
    localparam logic [2:0] PEAK_HALF   = 3'd3;
    localparam logic [2:0] PEAK_THIRD  = 3'd4;
    localparam logic [2:0] FIRST_STAGE = 3'd5;

    typedef struct packed {
        logic [31:0] word;
        logic [2:0]  rand_notes;   // bit i replaces note i+1 with a random value
        logic [7:0]  frames;       // DAC frames to capture
        logic [2:0]  kind;
    } stim_row_t;

    localparam stim_row_t rows [NUM_ROWS] = '{
        '{32'h0000_0000, 3'b000, 8'd3,  IDLE_WORDS},    // pins right after reset
        '{32'h0100_00B4, 3'b000, 8'd4,  IDLE_WORDS},    // ignored before sync
        '{`SYNC_WORD,    3'b000, 8'd2,  IDLE_WORDS},
        '{32'h0100_00B4, 3'b000, 8'd8,  ANY_NONZERO},
        '{32'h0000_0000, 3'b000, 8'd3,  IDLE_WORDS},    // rearm
        '{32'h0100_00B4, 3'b000, 8'd72, ENV_SHAPE},
        '{32'h0000_0000, 3'b000, 8'd3,  IDLE_WORDS},
        '{32'h0200_0000, 3'b011, 8'd24, PEAK_HALF},
        '{32'h0000_0000, 3'b000, 8'd3,  IDLE_WORDS},
        '{32'h0300_0000, 3'b111, 8'd24, PEAK_THIRD},
        '{32'h005A_5A5A, 3'b000, 8'd4,  IDLE_WORDS},    // count 0 mutes
        '{32'h0000_0000, 3'b000, 8'd3,  IDLE_WORDS},
        '{32'h0100_00B4, 3'b000, 8'd12, FIRST_STAGE}    // retrigger
    };

    logic       clk;
    logic       reset;
    logic       sck;
    logic       sdi;
    dac_pins_t  dac;
    int         seed;
    logic [7:0] words [$];

    piano_top i_piano_top (
        .clk   (clk),
        .reset (reset),
        .sck   (sck),
        .sdi   (sdi),
        .dac   (dac)
    );

    initial clk = 1'b0;

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    // mask bit 7-k adds note/2^k to the stage level
    function automatic logic [7:0] stage_level(input logic [7:0] note, input logic [7:0] mask);
        logic [7:0] acc;
        acc = 8'd0;
        for (int k = 0; k < 8; k++)
            if (mask[7 - k])
                acc = acc + (note >> k);
        return acc;
    endfunction

    function automatic logic [7:0] third_of(input logic [9:0] sum);
        logic [9:0] t;
        t = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);
        return t[7:0];
    endfunction

    function automatic logic [7:0] highest_word();
        logic [7:0] peak;
        peak = 8'd0;
        foreach (words[i])
            if (words[i] > peak)
                peak = words[i];
        return peak;
    endfunction

    function automatic logic [7:0] first_nonzero_word();
        logic [7:0] found;
        found = 8'd0;
        for (int i = words.size() - 1; i >= 0; i--)   // backwards so the earliest wins
            if (words[i] != 8'd0)
                found = words[i];
        return found;
    endfunction

    // sends MSB first with sck low then high for each bit
    task automatic send_spi_word(input logic [31:0] word);
        @(posedge clk);
        for (int i = 31; i >= 0; i--)
        begin
            sck <= 1'b0;
            sdi <= word[i];
            repeat (SCK_HALF) @(posedge clk);
            sck <= 1'b1;
            repeat (SCK_HALF) @(posedge clk);
        end
    endtask

    task automatic capture_frames(input int count);
        logic [7:0] bits;
        logic       prev_dclk;
        logic       prev_level;
        logic       seen;
        int         edges;
        int         low_cycles;
        int         waited;
        words.delete();
        seen       = 1'b0;
        waited     = 0;
        prev_level = dac.ldac;
        while (!seen && waited < FRAME_TIMEOUT)   // ldac rising starts a frame
        begin
            @(negedge clk);
            waited++;
            seen       = !prev_level && dac.ldac;
            prev_level = dac.ldac;
        end
        if (!seen)
            report_failure("timeout: ldac never rose to start a DAC frame");
        for (int f = 0; f < count; f++)
        begin
            bits       = 8'd0;
            edges      = 0;
            seen       = 1'b0;
            waited     = 0;
            prev_dclk  = dac.dclk;
            prev_level = dac.load;
            while (!seen && waited < FRAME_TIMEOUT)
            begin
                @(negedge clk);
                waited++;
                if (prev_dclk && !dac.dclk)
                begin
                    bits  = {bits[6:0], dac.data};   // idle bits fall off the top
                    edges = edges + 1;
                end
                seen       = prev_level && !dac.load;
                prev_dclk  = dac.dclk;
                prev_level = dac.load;
            end
            if (!seen)
                report_failure("timeout: load never fell at the end of a DAC word");
            check_value("dclk falls per frame", 32'(`DAC_PRE_BITS + `SAMPLE_W), 32'(edges));
            low_cycles = 0;
            while (!dac.load && low_cycles < FRAME_TIMEOUT)
            begin
                check_value("ldac during load", 32'd1, 32'(dac.ldac));
                low_cycles++;
                @(negedge clk);
            end
            if (!dac.load)
                report_failure("timeout: load never returned high after its strobe");
            check_value("load low cycles", 32'(`DAC_LOAD_CYCLES), 32'(low_cycles));
            low_cycles = 0;
            while (!dac.ldac && low_cycles < FRAME_TIMEOUT)
            begin
                low_cycles++;
                @(negedge clk);
            end
            if (!dac.ldac)
                report_failure("timeout: ldac never returned high after its strobe");
            check_value("ldac low cycles", 32'(`DAC_LDAC_CYCLES), 32'(low_cycles));
            words.push_back(bits);
        end
    endtask

    task automatic check_envelope(input logic [7:0] note);
        logic [7:0] expected_steps [$];
        logic [7:0] seen_steps [$];
        logic [7:0] level;
        int         n;
        for (int s = 0; s < `ENV_STAGES; s++)
        begin
            level = stage_level(note, env_gain_table[s]);
            if (expected_steps.size() == 0 || expected_steps[$] != level)
                expected_steps.push_back(level);
        end
        if (expected_steps[$] != 8'd0)
            expected_steps.push_back(8'd0);   // silent once the last stage ends
        foreach (words[i])
        begin
            if (seen_steps.size() == 0 && words[i] == 8'd0)
                continue;
            if (seen_steps.size() == 0 || seen_steps[$] != words[i])
                seen_steps.push_back(words[i]);
        end
        n = (seen_steps.size() < expected_steps.size()) ? seen_steps.size()
                                                         : expected_steps.size();
        for (int i = 0; i < n; i++)
            check_value("envelope step", 32'(expected_steps[i]), 32'(seen_steps[i]));
        check_value("envelope step count", 32'(expected_steps.size()), 32'(seen_steps.size()));
        check_value("envelope peak", 32'(note), 32'(highest_word()));
    endtask

    initial
    begin
        stim_row_t   row;
        logic [31:0] word;
        logic [7:0]  first;
        logic [9:0]  sum;
        int          rnd;
        seed  = 29142;
        reset <= 1'b1;
        sck   <= 1'b0;
        sdi   <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("load", 32'd1, 32'(dac.load));
        check_value("ldac", 32'd1, 32'(dac.ldac));
        check_value("dclk", 32'd0, 32'(dac.dclk));
        check_value("data", 32'd0, 32'(dac.data));
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row  = rows[r];
            word = row.word;
            for (int i = 0; i < 3; i++)
            begin
                if (row.rand_notes[i])
                begin
                    rnd = $random(seed);
                    word[8*i +: 8] = {1'b1, rnd[6:0]};   // keeps every stage level nonzero
                end
            end
            send_spi_word(word);
            capture_frames(int'(row.frames));
            case (row.kind)
                ANY_NONZERO:
                    if (highest_word() == 8'd0)
                        report_failure("no nonzero DAC word after the sync word");
                ENV_SHAPE:
                    check_envelope(word[7:0]);
                PEAK_HALF:
                begin
                    sum = 10'(word[7:0]) + 10'(word[15:8]);
                    check_value("peak word", 32'(8'(sum >> 1)), 32'(highest_word()));
                end
                PEAK_THIRD:
                begin
                    sum = 10'(word[7:0]) + 10'(word[15:8]) + 10'(word[23:16]);
                    check_value("peak word", 32'(third_of(sum)), 32'(highest_word()));
                end
                FIRST_STAGE:
                begin
                    first = first_nonzero_word();
                    if (first == 8'd0)
                        report_failure("no nonzero DAC word after the retriggered note");
                    else
                        check_value("first envelope word",
                                    32'(stage_level(word[7:0], env_gain_table[0])), 32'(first));
                end
                default:
                    foreach (words[i])
                        check_value("idle word", 32'd0, 32'(words[i]));
            endcase
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: voice/envelope_generator.sv
// per-voice envelope: steps through the gain table while the note is held and fades it to silence
`timescale 1ns/1ps
`include "piano_config.svh"

module envelope_generator
    import audio_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  sample_t       note,
    output voice_status_t voice
);

    localparam int CYC_W   = $clog2(`ENV_STAGE_CYCLES);
    localparam int STAGE_W = $clog2(`ENV_STAGES);

    logic [CYC_W-1:0]   cycle_cnt;
    logic [STAGE_W-1:0] stage;
    logic               active;
    logic               done;
    logic               running;
    gain_mask_t         mask;
    sample_t            terms [8];
    sample_t            term_sum;
    sample_t            level;

    assign running = (note != '0) && !done;
    assign mask    = env_gain_table[stage];

    // stage sequencing, a zero note rearms the voice
    always_ff @(posedge clk)
    begin
        if (reset || note == '0)
        begin
            cycle_cnt <= '0;
            stage     <= '0;
            active    <= 1'b0;
            done      <= 1'b0;
        end
        else if (!done)
        begin
            active <= 1'b1;
            if (cycle_cnt == CYC_W'(`ENV_STAGE_CYCLES - 1))
            begin
                cycle_cnt <= '0;
                if (stage == STAGE_W'(`ENV_STAGES - 1))
                begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
                else
                    stage <= stage + 1'b1;
            end
            else
                cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_comb
    begin
        term_sum = '0;
        for (int k = 0; k < 8; k++)
            term_sum = term_sum + terms[k];
    end

    // mask bit 7-k selects note/2^k
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            terms <= '{default: '0};
            level <= '0;
        end
        else
        begin
            for (int k = 0; k < 8; k++)
                terms[k] <= (running && mask[7 - k]) ? note >> k : '0;
            level <= term_sum;
        end
    end

    assign voice = '{sample: level, active: active, done: done};

endmodule

// File: voice/note_mixer.sv
// sums the three voices and scales the result by the voice count and by how the voices overlap
`timescale 1ns/1ps
`include "piano_config.svh"

module note_mixer
    import audio_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  voice_status_t voices [3],
    input  voice_count_t  count,
    output sample_t       mixed
);

    localparam int SUM_W = `SAMPLE_W + 2;

    logic             overlap_12;
    logic             overlap_23;
    logic             overlap_all;
    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] third;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            overlap_12  <= 1'b0;
            overlap_23  <= 1'b0;
            overlap_all <= 1'b0;
        end
        else
        begin
            overlap_12  <= voices[1].active & ~voices[0].done;
            overlap_23  <= voices[2].active & ~voices[1].done;
            overlap_all <= voices[2].active & ~voices[0].done & ~voices[1].done;
        end
    end

    assign sum = SUM_W'(voices[0].sample) + SUM_W'(voices[1].sample) +
                 SUM_W'(voices[2].sample);

    // about sum/3
    assign third = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);

    always_comb
    begin
        case (count)
            2'd1:
                mixed = sample_t'(sum);
            2'd2:
                mixed = overlap_12 ? sample_t'(sum >> 1) : sample_t'(sum);
            2'd3:
            begin
                if (overlap_all)
                    mixed = sample_t'(third);
                else if (overlap_23)
                    mixed = sample_t'(sum >> 1);
                else
                    mixed = sample_t'(sum);
            end
            default:
                mixed = '0;   // silent
        endcase
    end

endmodule
